/* include/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ##########################################################################
// board widths and map
// ##########################################################################

`define MEM_ADDR_W 18 // sram address bits.
`define MEM_DATA_W 16

// the one word that goes to the uart chip.
`define UART_ADDR 18'h0BF00

// queue depths, also the starting credit counts.
`define REQ_DEPTH 4
`define RSP_DEPTH 4

`define TIMEOUT_FACTOR 20 // watchdog scale.

`endif

/* design/bus_pkg.sv */
`include "mem_defs.svh"

package bus_pkg;

	// host request, one word.
	typedef struct packed {
		logic write;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata;
	} bus_req_t;

	// one per request, in request order.
	typedef struct packed {
		logic was_write; // write echoes its data.
		logic [`MEM_DATA_W-1:0] rdata;
	} bus_rsp_t;

endpackage

/* design/phy_pkg.sv */
`include "mem_defs.svh"

package phy_pkg;

	// sram side, strobes active low.
	typedef struct packed {
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] dout;
		logic doe; // drive the data bus.
		logic en_n;
		logic oe_n;
		logic we_n;
	} sram_pins_t;

	typedef struct packed {
		logic [`MEM_DATA_W-1:0] dout;
		logic doe;
		logic rdn;
		logic wrn;
	} uart_pins_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_STROBE,
		ST_FINISH
	} seq_state_t;

endpackage

/* design/credit_fifo.sv */
module credit_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst,

	input logic in_valid,
	input payload_t in_data,
	output logic in_credit,

	output logic out_valid,
	output payload_t out_data,
	input logic out_credit
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = 16;

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits; // downstream credits held.
	logic pop;

	assign pop = (count != '0) && (credits != '0);
	assign out_valid = pop;
	assign out_data = mem[rd_ptr];
	assign in_credit = pop; // one credit back per entry gone.

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({in_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({out_credit, pop})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end
endmodule

/* design/ram_uart.sv */
`include "mem_defs.svh"

module ram_uart
	import bus_pkg::*, phy_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic req_valid,
	input bus_req_t req,
	output logic req_credit,

	output logic rsp_valid,
	output bus_rsp_t rsp,
	input logic rsp_credit,

	output sram_pins_t sram,
	input logic [`MEM_DATA_W-1:0] sram_din,

	output uart_pins_t uart,
	input logic [`MEM_DATA_W-1:0] uart_din,
	input logic data_ready,
	input logic tbre,
	input logic tsre,

	output logic [15:0] tx_count
);
	localparam int CRD_W = $clog2(`RSP_DEPTH + 1);

	seq_state_t state;
	seq_state_t state_next;

	bus_req_t req_r;
	logic uart_sel; // latched address decode.
	logic [`MEM_DATA_W-1:0] rdata;
	logic [CRD_W-1:0] rsp_crd;
	logic started;
	logic active;
	logic strobing;
	logic tx_idle;
	logic done;

	// ##########################################################################
	// pins
	// ##########################################################################

	assign active = (state == ST_SETUP) || (state == ST_STROBE);
	assign strobing = state == ST_STROBE;

	assign sram.addr = req_r.addr;
	assign sram.dout = req_r.wdata;
	assign sram.doe = (state != ST_IDLE) && !uart_sel && req_r.write; // held past we rise.
	assign sram.en_n = !(active && !uart_sel);
	assign sram.oe_n = !(strobing && !uart_sel && !req_r.write);
	assign sram.we_n = !(strobing && !uart_sel && req_r.write);

	assign uart.dout = req_r.wdata;
	assign uart.doe = active && uart_sel && req_r.write;
	assign uart.wrn = !(active && uart_sel && req_r.write); // low for setup and strobe.
	assign uart.rdn = !(strobing && uart_sel && !req_r.write);

	// ##########################################################################
	// response
	// ##########################################################################

	assign tx_idle = tbre & tsre;

	// finish ends on a response credit, uart writes also wait for the chip.
	assign done = (state == ST_FINISH) && (rsp_crd != '0)
		&& (!(uart_sel && req_r.write) || tx_idle);

	assign rsp_valid = done;
	assign rsp.was_write = req_r.write;
	assign rsp.rdata = req_r.write ? req_r.wdata : rdata;

	// ##########################################################################
	// sequencer
	// ##########################################################################

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (req_valid) begin
					state_next = ST_SETUP;
				end
			end
			ST_SETUP: begin
				// uart read holds here until the chip has a byte.
				if (!uart_sel || req_r.write || data_ready) begin
					state_next = ST_STROBE;
				end
			end
			ST_STROBE: begin
				state_next = ST_FINISH;
			end
			ST_FINISH: begin
				if (done) begin
					state_next = ST_IDLE;
				end
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req_valid) begin
			req_r <= req;
			uart_sel <= req.addr == `UART_ADDR;
		end
		if (strobing && !req_r.write) begin
			rdata <= uart_sel ? uart_din : sram_din; // sampled as strobe ends.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= ST_IDLE;
			started <= 1'b0;
			req_credit <= 1'b0;
			rsp_crd <= CRD_W'(`RSP_DEPTH);
			tx_count <= '0;
		end else begin
			state <= state_next;
			started <= 1'b1;
			req_credit <= !started || done; // first idle, then each return.
			case ({rsp_credit, done})
				2'b10: rsp_crd <= rsp_crd + 1'b1;
				2'b01: rsp_crd <= rsp_crd - 1'b1;
				default: rsp_crd <= rsp_crd;
			endcase
			if (strobing && uart_sel && req_r.write) begin
				tx_count <= tx_count + 1'b1; // wraps.
			end
		end
	end
endmodule

/* design/mem_system.sv */
`include "mem_defs.svh"

module mem_system
	import bus_pkg::*, phy_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic req_valid,
	input bus_req_t req,
	output logic req_credit,

	output logic rsp_valid,
	output bus_rsp_t rsp,
	input logic rsp_credit,

	output sram_pins_t sram,
	input logic [`MEM_DATA_W-1:0] sram_din,

	output uart_pins_t uart,
	input logic [`MEM_DATA_W-1:0] uart_din,
	input logic data_ready,
	input logic tbre,
	input logic tsre,

	output logic [15:0] tx_count
);
	logic seq_req_valid;
	bus_req_t seq_req;
	logic seq_credit; // sequencer ready for one more.

	logic seq_rsp_valid;
	bus_rsp_t seq_rsp;
	logic rsp_q_credit;

	credit_fifo #(
		.payload_t(bus_req_t),
		.DEPTH(`REQ_DEPTH)
	) u_req_q (
		.clk(clk),
		.rst(rst),
		.in_valid(req_valid),
		.in_data(req),
		.in_credit(req_credit),
		.out_valid(seq_req_valid),
		.out_data(seq_req),
		.out_credit(seq_credit)
	);

	ram_uart u_seq (
		.clk(clk),
		.rst(rst),
		.req_valid(seq_req_valid),
		.req(seq_req),
		.req_credit(seq_credit),
		.rsp_valid(seq_rsp_valid),
		.rsp(seq_rsp),
		.rsp_credit(rsp_q_credit),
		.sram(sram),
		.sram_din(sram_din),
		.uart(uart),
		.uart_din(uart_din),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre),
		.tx_count(tx_count)
	);

	// host grants credits here.
	credit_fifo #(
		.payload_t(bus_rsp_t),
		.DEPTH(`RSP_DEPTH)
	) u_rsp_q (
		.clk(clk),
		.rst(rst),
		.in_valid(seq_rsp_valid),
		.in_data(seq_rsp),
		.in_credit(rsp_q_credit),
		.out_valid(rsp_valid),
		.out_data(rsp),
		.out_credit(rsp_credit)
	);
endmodule

/* test/ram_uart_props.sv */
module ram_uart_props
	import phy_pkg::*;
(
	input logic clk,
	input logic rst,
	input sram_pins_t sram,
	input uart_pins_t uart,
	input logic data_ready
);
	logic sram_busy;
	logic uart_busy;

	assign sram_busy = !sram.en_n || !sram.oe_n || !sram.we_n;
	assign uart_busy = !uart.rdn || !uart.wrn;

	// ##########################################################################
	// pin protocol
	// ##########################################################################

	a_one_chip: assert property (@(posedge clk) disable iff (!rst) !(sram_busy && uart_busy))
		else $error("sram and uart strobes low in the same cycle");

	a_oe_we: assert property (@(posedge clk) disable iff (!rst) !(!sram.oe_n && !sram.we_n))
		else $error("sram oe and we low together");

	a_sram_bus: assert property (@(posedge clk) disable iff (!rst) !(sram.doe && !sram.oe_n))
		else $error("sram data driven during a read");

	a_uart_bus: assert property (@(posedge clk) disable iff (!rst) !(uart.doe && !uart.rdn))
		else $error("uart data driven during a read");

	// read strobe only once the chip had a byte.
	a_rdn_ready: assert property (@(posedge clk) disable iff (!rst)
		$fell(uart.rdn) |-> $past(data_ready)) else $error("rdn fell before data_ready");
endmodule

/* test/mem_system_tb.sv */
`include "mem_defs.svh"

module mem_system_tb
	import bus_pkg::*, phy_pkg::*;
();
	localparam int N_OPS = 200;
	localparam int WATCHDOG = N_OPS * `REQ_DEPTH * `TIMEOUT_FACTOR * 8;
	localparam logic [`MEM_ADDR_W-1:0] WIN_BASE = 18'h0BEF8; // window spans the uart word.

	logic clk;
	logic rst;
	logic req_valid;
	bus_req_t req;
	logic req_credit;
	logic rsp_valid;
	bus_rsp_t rsp;
	logic rsp_credit;
	sram_pins_t sram;
	logic [`MEM_DATA_W-1:0] sram_din;
	uart_pins_t uart;
	logic [`MEM_DATA_W-1:0] uart_din;
	logic data_ready;
	logic tbre;
	logic tsre;
	logic [15:0] tx_count;

	int seed;
	int r;
	int val_errs;
	int proto_errs;
	int sent;
	int returned;
	int host_cred;
	int granted; // response credits not yet used.
	int grants;
	int rsp_seen;
	int uart_writes;
	int wrn_pulses;
	int rx_wait;
	int tx_busy;
	logic prev_rdn;
	logic prev_wrn;

	logic [`MEM_DATA_W-1:0] sram_mem [logic [`MEM_ADDR_W-1:0]];
	logic [`MEM_DATA_W-1:0] shadow [logic [`MEM_ADDR_W-1:0]];
	logic [`MEM_DATA_W-1:0] rx_bytes [$]; // handed out by the uart model.
	logic [`MEM_DATA_W-1:0] tx_expect [$];
	bus_rsp_t rsp_expect [$];
	bit from_uart [$];

	mem_system i_dut (.*);

	bind ram_uart ram_uart_props u_props (
		.clk(clk),
		.rst(rst),
		.sram(sram),
		.uart(uart),
		.data_ready(data_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired with %0d of %0d responses back", rsp_seen, N_OPS);
		$display("errors: %0d value, %0d protocol", val_errs, proto_errs);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ##########################################################################
	// helpers
	// ##########################################################################

	function automatic logic [`MEM_DATA_W-1:0] fill_word(input logic [`MEM_ADDR_W-1:0] a);
		return a[15:0] ^ {a[1:0], a[17:4]} ^ 16'h5a3c;
	endfunction

	task automatic value_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		val_errs++;
		$display("Fail %0t %s expected %h got %h", $time, name, exp, act);
	endtask

	task automatic protocol_error(input string what);
		proto_errs++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic check_reset_pins();
		logic [8:0] pins;
		pins = {sram.en_n, sram.oe_n, sram.we_n, uart.rdn, uart.wrn,
			sram.doe, uart.doe, req_credit, rsp_valid};
		assert (pins == 9'b11111_0000)
			else value_mismatch("{en_n,oe_n,we_n,rdn,wrn,doe,doe,req_credit,rsp_valid}",
				32'(9'b11111_0000), 32'(pins));
	endtask

	// sram chip, latches on the rising edge of we.
	always @(posedge sram.we_n) begin
		if (rst) begin
			assert (sram.doe) else protocol_error("sram write ended with data bus released");
			sram_mem[sram.addr] = sram.dout;
		end
	end

	task automatic drive_sram();
		r = $random(seed);
		if (!sram.oe_n || !sram.we_n) begin
			assert (!sram.en_n) else protocol_error("sram strobe with chip enable high");
		end
		if (!sram.oe_n) begin
			sram_din = sram_mem.exists(sram.addr) ? sram_mem[sram.addr]
				: fill_word(sram.addr);
		end else begin
			sram_din = 16'(r); // bus noise while the chip is off.
		end
	endtask

	task automatic run_uart_model();
		logic [`MEM_DATA_W-1:0] exp_tx;
		if (!uart.rdn) begin
			assert (data_ready) else protocol_error("rdn low while data_ready is low");
		end
		if (!uart.rdn && prev_rdn) begin
			rx_bytes.push_back(uart_din);
			data_ready = 1'b0;
			r = $random(seed);
			rx_wait = 1 + (r & 7);
		end else if (!data_ready) begin
			if (rx_wait > 0) begin
				rx_wait--;
			end else begin
				r = $random(seed);
				uart_din = 16'(r & 255);
				data_ready = 1'b1;
			end
		end
		if (!uart.wrn && prev_wrn) begin
			wrn_pulses++;
			assert (uart.doe) else protocol_error("wrn low with uart data bus released");
			assert (tx_expect.size() > 0) else protocol_error("wrn pulse with no uart write sent");
			if (tx_expect.size() > 0) begin
				exp_tx = tx_expect.pop_front();
				assert (uart.dout == exp_tx)
					else value_mismatch("uart.dout", 32'(exp_tx), 32'(uart.dout));
			end
			tbre = 1'b0;
			tsre = 1'b0;
			r = $random(seed);
			tx_busy = 2 + (r & 15);
		end else if (uart.wrn && tx_busy > 0) begin
			tx_busy--;
			tbre = tx_busy <= 1; // shift register empties last.
			tsre = tx_busy == 0;
		end
		prev_rdn = uart.rdn;
		prev_wrn = uart.wrn;
	endtask

	// ##########################################################################
	// host side and reference model
	// ##########################################################################

	task automatic collect_outputs();
		bus_rsp_t exp;
		if (req_credit) begin
			returned++;
			host_cred++;
			assert (returned <= sent) else protocol_error("request credit with nothing sent");
			assert (host_cred <= `REQ_DEPTH) else protocol_error("host holds too many credits");
		end
		if (rsp_valid) begin
			rsp_seen++;
			assert (granted > 0) else protocol_error("rsp_valid with no response credit granted");
			granted--;
			assert (rsp_expect.size() > 0) else protocol_error("response with no request open");
			if (rsp_expect.size() > 0) begin
				exp = rsp_expect.pop_front();
				if (from_uart.pop_front()) begin
					assert (rx_bytes.size() > 0) else protocol_error("uart read ended without rdn");
					if (rx_bytes.size() > 0) begin
						exp.rdata = rx_bytes.pop_front();
					end
				end
				assert (rsp.was_write == exp.was_write)
					else value_mismatch("rsp.was_write", 32'(exp.was_write), 32'(rsp.was_write));
				assert (rsp.rdata == exp.rdata)
					else value_mismatch("rsp.rdata", 32'(exp.rdata), 32'(rsp.rdata));
			end
		end
	endtask

	task automatic drive_host();
		bus_rsp_t exp;
		req_valid = 1'b0;
		rsp_credit = 1'b0;
		r = $random(seed);
		if (sent < N_OPS && host_cred > 0 && r[0]) begin
			req.write = r[1];
			req.addr = (r[4:2] == 3'd0) ? `UART_ADDR : WIN_BASE + 18'(r[11:8]);
			req.wdata = r[27:12];
			req_valid = 1'b1;
			host_cred--;
			sent++;
			exp.was_write = req.write;
			exp.rdata = req.wdata;
			if (req.addr == `UART_ADDR) begin
				if (req.write) begin
					tx_expect.push_back(req.wdata);
					uart_writes++;
				end
			end else if (req.write) begin
				shadow[req.addr] = req.wdata;
			end else begin
				exp.rdata = shadow.exists(req.addr) ? shadow[req.addr] : fill_word(req.addr);
			end
			rsp_expect.push_back(exp);
			from_uart.push_back(req.addr == `UART_ADDR && !req.write);
		end
		if (grants < N_OPS && r[5]) begin
			rsp_credit = 1'b1;
			granted++;
			grants++;
		end
	endtask

	task automatic tick();
		collect_outputs();
		run_uart_model();
		drive_sram();
		drive_host();
	endtask

	initial begin
		seed = 35647;
		host_cred = `REQ_DEPTH;
		rx_wait = 3;
		prev_rdn = 1'b1;
		prev_wrn = 1'b1;
		rst = 1'b0;
		req_valid = 1'b0;
		req = '0;
		rsp_credit = 1'b0;
		sram_din = '0;
		uart_din = '0;
		data_ready = 1'b0;
		tbre = 1'b1;
		tsre = 1'b1;
		repeat (10) @(negedge clk);
		check_reset_pins();
		rst = 1'b1;
		while (rsp_seen < N_OPS) begin
			@(negedge clk);
			tick();
		end
		repeat (10) begin // let the last credits come home.
			@(negedge clk);
			tick();
		end
		assert (tx_count == 16'(uart_writes))
			else value_mismatch("tx_count", 32'(16'(uart_writes)), 32'(tx_count));
		assert (wrn_pulses == uart_writes)
			else value_mismatch("wrn pulses", 32'(uart_writes), 32'(wrn_pulses));
		assert (host_cred == `REQ_DEPTH)
			else value_mismatch("host request credits", 32'(`REQ_DEPTH), 32'(host_cred));
		assert (rsp_expect.size() == 0) else protocol_error("responses still missing at the end");
		$display("errors: %0d value, %0d protocol", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end
endmodule

/* mem_system.f */
+incdir+include
design/bus_pkg.sv
design/phy_pkg.sv
design/credit_fifo.sv
design/ram_uart.sv
design/mem_system.sv
test/ram_uart_props.sv
test/mem_system_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mem_system_tb
FILELIST := mem_system.f
OBJ_DIR  := obj_dir
PASS_MSG := SIMULATION PASSED

.PHONY: sim clean

# build, run, then look for the pass line in the output.
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
